// File: dtim_macros.svh
`ifndef DTIM_MACROS_SVH
`define DTIM_MACROS_SVH

// Store geometry.
`define DTIM_SETS 16
`define DTIM_WORDS 4
`define DTIM_SET_BITS 4
`define DTIM_WORD_BITS 2

// Remaining upper address bits.
`define DTIM_TAG_BITS (30 - `DTIM_SET_BITS - `DTIM_WORD_BITS)

// Window is base inclusive, top exclusive.
`define DTIM_BASE_ADDR 32'h0000_1000
`define DTIM_TOP_ADDR 32'h0000_2000

`endif

// File: dtim_pkg.sv
`default_nettype none

`include "dtim_macros.svh"

package dtim_pkg;

  typedef struct packed {
    logic valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] wstrb;
  } mem_in_type;

  typedef struct packed {
    logic ready;
    logic [31:0] rdata;
  } mem_out_type;

  typedef struct packed {
    logic valid;
    logic fence;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] wstrb; // Zero for a read.
  } dtim_in_type;

  typedef struct packed {
    logic ready;
    logic [31:0] rdata;
  } dtim_out_type;

  typedef struct packed {
    logic [`DTIM_TAG_BITS-1:0] tag;
    logic [`DTIM_SET_BITS-1:0] set;
    logic [`DTIM_WORD_BITS-1:0] word; // Selects the bank.
    logic [1:0] offset;
  } dtim_addr_fields_type;

  typedef union packed {
    logic [31:0] raw;
    dtim_addr_fields_type f;
  } dtim_addr_union;

  typedef struct packed {
    logic lock;
    logic dirty;
    logic [`DTIM_TAG_BITS-1:0] tag;
    logic [31:0] data;
  } dtim_entry_type;

  typedef struct packed {
    logic wen;
    logic [`DTIM_SET_BITS-1:0] waddr;
    logic [`DTIM_SET_BITS-1:0] raddr;
    dtim_entry_type wdata;
  } dtim_ram_in_type;

  typedef struct packed {
    dtim_entry_type rdata;
  } dtim_ram_out_type;

endpackage

`default_nettype wire

// File: dtim_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtim_macros.svh"

module dtim_ram (
  input wire clock,
  input wire dtim_pkg::dtim_ram_in_type ram_in,
  output dtim_pkg::dtim_ram_out_type ram_out
);

  // Entries come up unlocked.
  dtim_pkg::dtim_entry_type mem [`DTIM_SETS] = '{default: '0};

  logic [`DTIM_SET_BITS-1:0] raddr_q;

  always_ff @(posedge clock) begin
    raddr_q <= ram_in.raddr;
    if (ram_in.wen) begin
      mem[ram_in.waddr] <= ram_in.wdata;
    end
  end

  assign ram_out.rdata = mem[raddr_q]; // One cycle after the address.

endmodule

`default_nettype wire

// File: dtim_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtim_macros.svh"

module dtim_ctrl (
  input wire clock,
  input wire reset,
  input wire dtim_pkg::dtim_ram_out_type bank_out [`DTIM_WORDS],
  output dtim_pkg::dtim_ram_in_type bank_in [`DTIM_WORDS],
  input wire dtim_pkg::dtim_in_type dtim_in,
  output dtim_pkg::dtim_out_type dtim_out,
  input wire dtim_pkg::mem_out_type dmem_out,
  output dtim_pkg::mem_in_type dmem_in
);

  localparam logic [1:0] st_hit = 2'd0;
  localparam logic [1:0] st_miss = 2'd1;
  localparam logic [1:0] st_pass = 2'd2;
  localparam logic [1:0] st_fence = 2'd3;

  typedef struct packed {
    logic fence;
    logic wren;
    dtim_pkg::dtim_addr_union addr;
    logic [31:0] data;
    logic [3:0] strb;
  } req_type;

  typedef struct packed {
    logic [1:0] state;
    logic req_valid;
    logic wb_wait; // Write-back out, waiting for memory.
    logic [`DTIM_SET_BITS-1:0] fset;
    logic [`DTIM_WORD_BITS-1:0] fword;
  } ctrl_type;

  req_type req_q;
  req_type req_d;
  ctrl_type ctrl_q;
  ctrl_type ctrl_d;

  logic [`DTIM_WORD_BITS-1:0] sel_word;
  dtim_pkg::dtim_entry_type entry;
  dtim_pkg::dtim_addr_union wb_addr;
  logic in_window;
  logic tag_match;

  logic ram_wen;
  logic [`DTIM_SET_BITS-1:0] ram_wset;
  logic [`DTIM_WORD_BITS-1:0] ram_wword;
  logic [`DTIM_SET_BITS-1:0] ram_rset;
  dtim_pkg::dtim_entry_type ram_wentry;

  function automatic logic [31:0] merge_bytes(
    input logic [31:0] base,
    input logic [31:0] update,
    input logic [3:0] strb
  );
    logic [31:0] result;
    result = base;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = update[8*b +: 8];
      end
    end
    return result;
  endfunction

  always_comb begin
    req_d = req_q;
    if (dtim_in.valid) begin
      req_d.fence = dtim_in.fence;
      req_d.wren = |dtim_in.wstrb;
      req_d.addr.raw = {dtim_in.addr[31:2], 2'b00};
      req_d.data = dtim_in.wdata;
      req_d.strb = dtim_in.wstrb;
    end
  end

  // The fence walk reads its own entry, otherwise the request's bank.
  assign sel_word = (ctrl_q.state == st_fence) ? ctrl_q.fword : req_q.addr.f.word;
  assign entry = bank_out[sel_word].rdata;

  assign in_window = (req_q.addr.raw >= `DTIM_BASE_ADDR) &&
                     (req_q.addr.raw < `DTIM_TOP_ADDR);
  assign tag_match = (entry.tag == req_q.addr.f.tag);

  always_comb begin
    wb_addr.f.tag = entry.tag;
    wb_addr.f.set = ctrl_q.fset;
    wb_addr.f.word = ctrl_q.fword;
    wb_addr.f.offset = 2'b00;
  end

  always_comb begin
    ctrl_d = ctrl_q;
    ctrl_d.req_valid = dtim_in.valid;

    dmem_in = '0;
    dtim_out = '0;

    ram_wen = 1'b0;
    ram_wset = req_q.addr.f.set;
    ram_wword = req_q.addr.f.word;
    ram_wentry = '0;

    case (ctrl_q.state)
      st_hit: begin
        if (ctrl_q.req_valid) begin
          if (req_q.fence) begin
            ctrl_d.state = st_fence;
            ctrl_d.fset = '0;
            ctrl_d.fword = '0;
            ctrl_d.wb_wait = 1'b0;
          end else if (!in_window || (entry.lock && !tag_match)) begin
            ctrl_d.state = st_pass; // Entry held by another tag.
            dmem_in.valid = 1'b1;
            dmem_in.addr = req_q.addr.raw;
            dmem_in.wdata = req_q.wren ? req_q.data : '0;
            dmem_in.wstrb = req_q.strb;
          end else if (!entry.lock) begin
            ctrl_d.state = st_miss; // Fetch the word first.
            dmem_in.valid = 1'b1;
            dmem_in.addr = req_q.addr.raw;
          end else begin
            ram_wen = req_q.wren;
            ram_wentry.lock = 1'b1;
            ram_wentry.dirty = 1'b1;
            ram_wentry.tag = entry.tag;
            ram_wentry.data = merge_bytes(entry.data, req_q.data, req_q.strb);
            dtim_out.ready = 1'b1;
            dtim_out.rdata = req_q.wren ? '0 : entry.data;
          end
        end
      end

      st_miss: begin
        if (dmem_out.ready) begin
          ram_wen = 1'b1;
          ram_wentry.lock = 1'b1;
          ram_wentry.dirty = req_q.wren;
          ram_wentry.tag = req_q.addr.f.tag;
          ram_wentry.data = merge_bytes(dmem_out.rdata, req_q.data, req_q.strb);
          dtim_out.ready = 1'b1;
          dtim_out.rdata = req_q.wren ? '0 : dmem_out.rdata;
          ctrl_d.state = st_hit;
        end
      end

      st_pass: begin
        if (dmem_out.ready) begin
          dtim_out.ready = 1'b1;
          dtim_out.rdata = req_q.wren ? '0 : dmem_out.rdata;
          ctrl_d.state = st_hit;
        end
      end

      st_fence: begin
        ram_wset = ctrl_q.fset;
        ram_wword = ctrl_q.fword;
        if (!ctrl_q.wb_wait && entry.lock && entry.dirty) begin
          dmem_in.valid = 1'b1;
          dmem_in.addr = wb_addr.raw;
          dmem_in.wdata = entry.data;
          dmem_in.wstrb = 4'hf;
          ctrl_d.wb_wait = 1'b1;
        end else if (!ctrl_q.wb_wait || dmem_out.ready) begin
          ctrl_d.wb_wait = 1'b0;
          ram_wen = 1'b1; // Clear the entry.
          ctrl_d.fword = ctrl_q.fword + 1'b1;
          if (&ctrl_q.fword) begin
            ctrl_d.fset = ctrl_q.fset + 1'b1;
            if (&ctrl_q.fset) begin
              ctrl_d.state = st_hit;
              dtim_out.ready = 1'b1; // Walk done.
            end
          end
        end
      end

      default: begin
        ctrl_d.state = st_hit;
      end
    endcase
  end

  // Read address follows the next-state set so data lands a cycle later.
  assign ram_rset = (ctrl_d.state == st_fence) ? ctrl_d.fset : req_d.addr.f.set;

  always_comb begin
    for (int i = 0; i < `DTIM_WORDS; i++) begin
      bank_in[i].wen = ram_wen && (ram_wword == `DTIM_WORD_BITS'(i));
      bank_in[i].waddr = ram_wset;
      bank_in[i].raddr = ram_rset;
      bank_in[i].wdata = ram_wentry;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ctrl_q.state <= st_hit;
      ctrl_q.req_valid <= 1'b0;
      ctrl_q.wb_wait <= 1'b0;
      ctrl_q.fset <= '0;
      ctrl_q.fword <= '0;
    end else begin
      ctrl_q <= ctrl_d;
    end
  end

  always_ff @(posedge clock) begin
    req_q <= req_d;
  end

endmodule

`default_nettype wire

// File: dtim.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtim_macros.svh"

module dtim (
  input wire clock,
  input wire reset,
  input wire dtim_pkg::dtim_in_type dtim_in,
  output dtim_pkg::dtim_out_type dtim_out,
  input wire dtim_pkg::mem_out_type dmem_out,
  output dtim_pkg::mem_in_type dmem_in
);

  wire dtim_pkg::dtim_ram_in_type bank_in [`DTIM_WORDS];
  wire dtim_pkg::dtim_ram_out_type bank_out [`DTIM_WORDS];

  // One bank per word of a set.
  for (genvar i = 0; i < `DTIM_WORDS; i++) begin : g_bank
    dtim_ram i_ram (
      .clock   (clock),
      .ram_in  (bank_in[i]),
      .ram_out (bank_out[i])
    );
  end

  dtim_ctrl i_ctrl (
    .clock    (clock),
    .reset    (reset),
    .bank_out (bank_out),
    .bank_in  (bank_in),
    .dtim_in  (dtim_in),
    .dtim_out (dtim_out),
    .dmem_out (dmem_out),
    .dmem_in  (dmem_in)
  );

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
  input wire clock,
  input wire reset,
  input wire dtim_pkg::mem_in_type mem_in,
  output dtim_pkg::mem_out_type mem_out
);

  localparam int mem_words = 4096;

  logic [31:0] mem_data [mem_words]; // Covers 0x0000 to 0x3fff.
  logic [31:0] lat_state;
  logic [1:0] wait_count;
  logic [11:0] pend_index;
  logic busy;
  logic overlap; // Request seen while another was outstanding.

  function automatic logic [31:0] backing_fill(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ 32'h5bd1_e995;
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    for (int i = 0; i < mem_words; i++) begin
      mem_data[i] = backing_fill(32'(i) << 2);
    end
  end

  always @(posedge clock) begin
    if (!reset) begin
      mem_out <= '0;
      busy <= 1'b0;
      overlap <= 1'b0;
      wait_count <= '0;
      pend_index <= '0;
      lat_state <= 32'hbee6;
    end else begin
      mem_out.ready <= 1'b0;
      if (mem_in.valid) begin
        if (busy) begin
          overlap <= 1'b1;
        end
        for (int b = 0; b < 4; b++) begin
          if (mem_in.wstrb[b]) begin
            mem_data[mem_in.addr[13:2]][8*b +: 8] <= mem_in.wdata[8*b +: 8];
          end
        end
        busy <= 1'b1;
        pend_index <= mem_in.addr[13:2];
        wait_count <= lat_state[1:0]; // Zero to three extra cycles.
        lat_state <= xorshift(lat_state);
      end else if (busy) begin
        if (wait_count == 2'd0) begin
          busy <= 1'b0;
          mem_out.ready <= 1'b1;
          mem_out.rdata <= mem_data[pend_index];
        end else begin
          wait_count <= wait_count - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_dtim.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtim_macros.svh"

module tb_dtim;

  localparam int num_ops = 400;
  localparam int req_timeout = 64;
  localparam int fence_timeout = 2000;
  localparam int mem_words = 4096;
  localparam int class_hit = 0;
  localparam int class_miss = 1;
  localparam int class_pass = 2;

  logic clock;
  logic reset;
  dtim_pkg::dtim_in_type dtim_in;
  dtim_pkg::dtim_out_type dtim_out;
  dtim_pkg::mem_in_type dmem_in;
  dtim_pkg::mem_out_type dmem_out;

  logic [31:0] rng = 32'hbee6;
  logic [31:0] ref_mem [mem_words]; // Core view of memory.
  logic touched [mem_words];
  logic lock_model [`DTIM_SETS][`DTIM_WORDS];
  logic [`DTIM_TAG_BITS-1:0] tag_model [`DTIM_SETS][`DTIM_WORDS];

  dtim i_dtim (
    .clock    (clock),
    .reset    (reset),
    .dtim_in  (dtim_in),
    .dtim_out (dtim_out),
    .dmem_out (dmem_out),
    .dmem_in  (dmem_in)
  );

  tb_mem_model i_mem (
    .clock   (clock),
    .reset   (reset),
    .mem_in  (dmem_in),
    .mem_out (dmem_out)
  );

  initial clock = 1'b0;
  always #10 clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] backing_fill(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ 32'h5bd1_e995;
  endfunction

  function automatic int predict_class(input logic [31:0] addr);
    dtim_pkg::dtim_addr_union au;
    au.raw = addr;
    if (addr < `DTIM_BASE_ADDR || addr >= `DTIM_TOP_ADDR) begin
      return class_pass;
    end
    if (!lock_model[au.f.set][au.f.word]) begin
      return class_miss;
    end
    if (tag_model[au.f.set][au.f.word] == au.f.tag) begin
      return class_hit;
    end
    return class_pass; // Entry held by another tag.
  endfunction

  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "Stopping at the first error.");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("** Error: %s is %h, expected %h", name, got, expected);
      stop_with_failure();
    end
  endtask

  task automatic clear_tag_model();
    for (int s = 0; s < `DTIM_SETS; s++) begin
      for (int w = 0; w < `DTIM_WORDS; w++) begin
        lock_model[s][w] = 1'b0;
        tag_model[s][w] = '0;
      end
    end
  endtask

  task automatic pick_address(output logic [31:0] addr);
    logic [31:0] low;
    rng = xorshift(rng);
    low = {24'h0, rng[7:2], 2'b00};
    case (rng[10:8])
      3'd0, 3'd1: addr = `DTIM_BASE_ADDR | low;
      3'd2, 3'd3: addr = (`DTIM_BASE_ADDR + 32'h100) | low; // Aliases the line above.
      3'd4: addr = (`DTIM_TOP_ADDR - 32'h100) | low;
      3'd5: addr = (`DTIM_BASE_ADDR - 32'h100) | low; // Just below.
      default: addr = `DTIM_TOP_ADDR | low; // Just above.
    endcase
  endtask

  // Pulses valid, then waits for ready while recording memory requests.
  task automatic run_request(input dtim_pkg::dtim_in_type req, input int limit,
                             output logic [31:0] rdata, output int cycles,
                             output int mem_count, output dtim_pkg::mem_in_type mem_req);
    logic done;
    done = 1'b0;
    cycles = 0;
    mem_count = 0;
    mem_req = '0;
    rdata = '0;
    @(posedge clock);
    #1;
    dtim_in = req;
    @(posedge clock);
    #1;
    dtim_in.valid = 1'b0;
    while (!done) begin
      @(negedge clock);
      cycles++;
      if (i_mem.overlap) begin
        $display("A memory request was issued while another was still outstanding.");
        stop_with_failure();
      end
      if (dmem_in.valid) begin
        if (mem_count == 0) begin
          mem_req = dmem_in;
        end
        mem_count++;
      end
      if (dtim_out.ready) begin
        done = 1'b1;
        rdata = dtim_out.rdata;
      end else if (cycles >= limit) begin
        $display("Timeout: the DTIM gave no ready within %0d cycles.", limit);
        stop_with_failure();
      end
    end
  endtask

  task automatic run_access(input dtim_pkg::dtim_in_type req);
    dtim_pkg::mem_in_type mem_req;
    dtim_pkg::dtim_addr_union au;
    logic [31:0] rdata;
    logic [31:0] expected;
    logic [31:0] mask;
    int kind;
    int cycles;
    int mem_count;
    int idx;
    au.raw = req.addr;
    idx = int'(req.addr[13:2]);
    kind = predict_class(req.addr);
    expected = ref_mem[idx];
    run_request(req, req_timeout, rdata, cycles, mem_count, mem_req);
    if (req.wstrb == 4'h0) begin
      check_value("dtim_out.rdata", rdata, expected);
    end else begin
      check_value("dtim_out.rdata", rdata, 32'h0);
    end
    if (kind == class_hit) begin
      check_value("hit latency", cycles, 1);
      check_value("dmem_in.valid count", mem_count, 0);
    end else begin
      check_value("dmem_in.valid count", mem_count, 1);
      check_value("dmem_in.addr", mem_req.addr, req.addr);
      if (kind == class_pass) begin
        check_value("dmem_in.wdata", mem_req.wdata, (req.wstrb != 4'h0) ? req.wdata : 32'h0);
        check_value("dmem_in.wstrb", mem_req.wstrb, req.wstrb);
      end else begin
        check_value("dmem_in.wdata", mem_req.wdata, 32'h0); // Plain fetch.
        check_value("dmem_in.wstrb", mem_req.wstrb, 4'h0);
        lock_model[au.f.set][au.f.word] = 1'b1;
        tag_model[au.f.set][au.f.word] = au.f.tag;
      end
    end
    mask = {{8{req.wstrb[3]}}, {8{req.wstrb[2]}}, {8{req.wstrb[1]}}, {8{req.wstrb[0]}}};
    ref_mem[idx] = (expected & ~mask) | (req.wdata & mask);
    touched[idx] = 1'b1;
  endtask

  task automatic run_fence();
    dtim_pkg::dtim_in_type req;
    dtim_pkg::mem_in_type mem_req;
    logic [31:0] rdata;
    int cycles;
    int mem_count;
    req = '0;
    req.valid = 1'b1;
    req.fence = 1'b1;
    run_request(req, fence_timeout, rdata, cycles, mem_count, mem_req);
    for (int i = 0; i < mem_words; i++) begin
      if (touched[i]) begin
        check_value($sformatf("backing word at %h", 32'(i) << 2), i_mem.mem_data[i],
                    ref_mem[i]);
      end
    end
    clear_tag_model(); // Every entry is unlocked now.
  endtask

  initial begin
    dtim_pkg::dtim_in_type req;
    logic [31:0] addr;
    reset = 1'b0;
    dtim_in = '0;
    for (int i = 0; i < mem_words; i++) begin
      ref_mem[i] = backing_fill(32'(i) << 2);
      touched[i] = 1'b0;
    end
    clear_tag_model();

    repeat (10) begin
      @(posedge clock);
      #1;
      check_value("dtim_out.ready", dtim_out.ready, 1'b0);
      check_value("dmem_in.valid", dmem_in.valid, 1'b0);
    end
    reset = 1'b1;
    repeat (3) begin
      @(negedge clock);
      check_value("dtim_out.ready", dtim_out.ready, 1'b0);
      check_value("dmem_in.valid", dmem_in.valid, 1'b0);
    end

    for (int n = 0; n < num_ops; n++) begin
      rng = xorshift(rng);
      if (rng[3:0] == 4'h0) begin
        run_fence();
      end else begin
        req = '0;
        req.valid = 1'b1;
        pick_address(addr);
        req.addr = addr;
        rng = xorshift(rng);
        if (rng[0]) begin
          if (rng[1]) begin
            req.wstrb = 4'hf;
          end else begin
            req.wstrb = (rng[5:2] == 4'h0) ? 4'b0110 : rng[5:2];
          end
        end
        rng = xorshift(rng);
        req.wdata = rng; // Reads carry junk data too.
        run_access(req);
      end
    end
    run_fence();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
dtim_pkg.sv
dtim_ram.sv
dtim_ctrl.sv
dtim.sv
tb_mem_model.sv
tb_dtim.sv
